// File: Bender.yml
package:
  name: cart_monitor

sources:
  - common/cart_pkg.sv
  - cart_bus/cart_ram.sv
  - cart_bus/cart_bus_port.sv
  - hw/host_regs.sv
  - hw/trigger_router.sv
  - hw/cart_monitor_top.sv
  - target: test
    files:
      - dv/cart_monitor_tb.sv

// File: cart_bus/cart_bus_port.sv
`timescale 1ns/1ps

module cart_bus_port import cart_pkg::*; #(
	parameter int RAM_AW = 12
) (
	input  logic              cpuclk,
	input  logic              f_reset,
	input  cart_pins_t        cart,
	input  cart_ctl_t         ctl,
	input  logic [7:0]        rom_data,
	output logic [RAM_AW-1:0] ram_adr,
	output logic              cart_wr,
	output logic [7:0]        wdata,
	output logic [7:0]        cart_data_out,
	output logic              cart_data_oe,
	output logic              shifter_dir,
	output logic              shifter_en,
	output logic              cart_reset_drive,
	output bus_snapshot_t     snapshot
);

	cart_pins_t pins;
	logic       any_cs;
	logic       rd_cs;
	logic       data_oe_n;
	logic       dir_n;
	logic       ovr;

	// single input register stage.
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			pins <= '0;
		else
			pins <= cart;
	end

	// ************************************************************************
	// data direction sequence
	// ************************************************************************

	// the shifter turns first on a read, the data drivers turn off first after it.
	always_comb begin
		any_cs    = pins.cs_rom || (pins.cs_xram && pins.adr[13] && !pins.adr[14]);
		rd_cs     = pins.rd && any_cs;
		data_oe_n = cart_data_oe;
		dir_n     = shifter_dir;
		shifter_en = any_cs;

		if (rd_cs) begin
			dir_n = 1'b1;
			if (shifter_dir)
				data_oe_n = 1'b1;                // one cycle after the shifter.
		end else begin
			data_oe_n = 1'b0;
			if (cart_data_oe)
				shifter_en = 1'b0;               // keep the shifter off while oe drops.
			else
				dir_n = 1'b0;
		end
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			cart_data_oe     <= 1'b0;
			shifter_dir      <= 1'b0;
			cart_reset_drive <= 1'b0;
			ovr              <= 1'b0;
		end else begin
			cart_data_oe     <= data_oe_n;
			shifter_dir      <= dir_n;
			cart_reset_drive <= (cart_reset_drive || ctl.reset_set) && !ctl.reset_clr;
			ovr              <= (ovr || ctl.ovr_set) && !ctl.ovr_clr;
		end
	end

	// ************************************************************************
	// ram side and outputs
	// ************************************************************************

	assign ram_adr = pins.adr[RAM_AW-1:0];
	assign cart_wr = pins.wr && pins.cs_xram && pins.adr[13];
	assign wdata   = pins.data;

	assign cart_data_out = ovr ? ctl.ovr_data : rom_data;

	always_comb begin
		snapshot          = '0;
		snapshot.reset    = pins.reset;
		snapshot.phi      = pins.phi;
		snapshot.wr       = pins.wr;
		snapshot.rd       = pins.rd;
		snapshot.cs_xram  = pins.cs_xram;
		snapshot.data_dir = cart_data_oe;
		snapshot.data     = pins.data;
		snapshot.cs_rom   = pins.cs_rom;
		snapshot.adr      = pins.adr;
	end

	a_dir_before_oe: assert property (@(posedge cpuclk) disable iff (f_reset)
		$rose(cart_data_oe) |-> shifter_dir && $past(shifter_dir));

endmodule

// File: cart_bus/cart_ram.sv
`timescale 1ns/1ps

module cart_ram import cart_pkg::*; #(
	parameter int RAM_AW = 12
) (
	input  logic              cpuclk,
	input  logic              host_wr,
	input  logic [RAM_AW-1:0] host_adr,
	input  logic [7:0]        host_wdata,
	output logic [7:0]        host_rdata,
	input  logic [RAM_AW-1:0] cart_adr,
	input  logic              cart_wr,
	input  logic [7:0]        cart_wdata,
	output logic [7:0]        rom_data
);

	localparam int DEPTH = 1 << RAM_AW;

	logic [7:0] ro_mem [DEPTH];
	logic [7:0] wo_mem [DEPTH];

	// ************************************************************************
	// rom image, host writes it and the cartridge reads it
	// ************************************************************************

	always_ff @(posedge cpuclk) begin
		if (host_wr)
			ro_mem[host_adr] <= host_wdata;
		rom_data <= ro_mem[cart_adr];            // ready one cycle after sampling.
	end

	// ************************************************************************
	// capture ram, the cartridge writes it and the host reads it
	// ************************************************************************

	always_ff @(posedge cpuclk) begin
		if (cart_wr)
			wo_mem[cart_adr] <= cart_wdata;
		host_rdata <= wo_mem[host_adr];
	end

endmodule

// File: common/cart_pkg.sv
package cart_pkg;

	// ************************************************************************
	// address map and widths
	// ************************************************************************

	localparam int HOST_DW = 8;                          // host data bus.
	localparam int CART_AW = 15;                         // cartridge address bus.
	localparam int ROUTE_W = 4;                          // route field in the atom word.

	localparam logic [15:0] CART_RAM_BASE = 16'h1000;    // 4 KiB cart ram window.
	localparam logic [15:0] ATOM_BASE     = 16'hff10;    // atomic load register, 4 bytes.
	localparam logic [15:0] ONES_ADR      = 16'hff14;    // always-one routes.
	localparam logic [15:0] PA_BASE       = 16'hff40;    // port A block, 4 registers.
	localparam logic [15:0] DUT_BASE      = 16'hff50;    // dut bus block, 4 registers.

	localparam logic [HOST_DW-1:0] UNMAPPED_READ = 8'hff;

	// ************************************************************************
	// bus types
	// ************************************************************************

	// cartridge pins after the input register, all active high.
	typedef struct packed {
		logic [CART_AW-1:0] adr;
		logic [7:0]         data;
		logic               rd;
		logic               wr;
		logic               cs_rom;
		logic               cs_xram;
		logic               phi;
		logic               reset;
	} cart_pins_t;

	// compare word layout, also the host read-back layout.
	typedef struct packed {
		logic [1:0]         pad;       // port A bit was here, held at zero.
		logic               reset;
		logic               phi;
		logic               wr;
		logic               rd;
		logic               cs_xram;
		logic               data_dir;
		logic [7:0]         data;
		logic               cs_rom;
		logic [CART_AW-1:0] adr;
	} bus_snapshot_t;

	typedef struct packed {
		logic [31-ROUTE_W:0] pad;
		logic [ROUTE_W-1:0]  route;
	} atom_routes_t;

	// the atom word is read either as a compare word or as a route select.
	typedef union packed {
		bus_snapshot_t compare;
		atom_routes_t  routes;
	} atom_u;

	typedef struct packed {
		logic [15:0]        adr;
		logic [HOST_DW-1:0] wdata;
		logic               wr;
		logic               rd;
	} host_req_t;

	typedef struct packed {
		logic       reset_set;
		logic       reset_clr;
		logic       ovr_set;
		logic       ovr_clr;
		logic [7:0] ovr_data;
	} cart_ctl_t;

	typedef struct packed {
		bus_snapshot_t      cmp_value;
		bus_snapshot_t      cmp_mask;
		logic [ROUTE_W-1:0] cmp_routes;
		logic [ROUTE_W-1:0] pa_trig_set;
		logic [ROUTE_W-1:0] pa_trig_clr;
		logic [ROUTE_W-1:0] ones_routes;
		logic [7:0]         pa_set;
		logic [7:0]         pa_clr;
		logic               pa_strobe;
	} trig_cfg_t;

endpackage

// File: dv/cart_monitor_tb.sv
`timescale 1ns/1ps

module cart_monitor_tb import cart_pkg::*; ();

	localparam int    RAM_AW     = 12;
	localparam int    NUM_ROUTES = 4;
	localparam int    WAIT_LIMIT = 40;
	localparam string TRACE      = "dv/cart_monitor_trace.txt";

	localparam logic [7:0] CTL_READ   = 8'h05;   // rd with cs_rom.
	localparam logic [7:0] CTL_XWRITE = 8'h0a;   // wr with cs_xram.

	logic                  cpuclk;
	logic                  f_reset;
	host_req_t             host;
	logic [HOST_DW-1:0]    rdata;
	cart_pins_t            cart;
	logic [7:0]            cart_data_out;
	logic                  cart_data_oe;
	logic                  shifter_dir;
	logic                  shifter_en;
	logic                  cart_reset_drive;
	logic [NUM_ROUTES-1:0] routes;
	logic [7:0]            pa_out;

	logic [7:0] rom_model  [1 << RAM_AW];   // rom image as the host wrote it.
	logic [7:0] xram_model [1 << RAM_AW];   // bytes the cartridge wrote.
	string      test_name;

	cart_monitor_top #(
		.RAM_AW     (RAM_AW),
		.NUM_ROUTES (NUM_ROUTES)
	) u_cart_monitor_top (
		.cpuclk           (cpuclk),
		.f_reset          (f_reset),
		.host             (host),
		.rdata            (rdata),
		.cart             (cart),
		.cart_data_out    (cart_data_out),
		.cart_data_oe     (cart_data_oe),
		.shifter_dir      (shifter_dir),
		.shifter_en       (shifter_en),
		.cart_reset_drive (cart_reset_drive),
		.routes           (routes),
		.pa_out           (pa_out)
	);

	always #5 cpuclk = ~cpuclk;

	// ************************************************************************
	// checks
	// ************************************************************************

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_routes(input logic [NUM_ROUTES-1:0] exp,
			input logic [NUM_ROUTES-1:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error %s routes: expected %h, actual %h",
				test_name, exp, act));
	endtask

	task automatic check_pa(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error %s pa_out: expected %h, actual %h",
				test_name, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %b, actual %b",
				test_name, what, exp, act));
	endtask

	// ************************************************************************
	// pin and snapshot builders
	// ************************************************************************

	function automatic cart_pins_t make_pins(input logic [15:0] addr, input logic [7:0] data,
			input logic [7:0] ctl);
		cart_pins_t p;
		p.adr     = addr[CART_AW-1:0];
		p.data    = data;
		p.rd      = ctl[0];
		p.wr      = ctl[1];
		p.cs_rom  = ctl[2];
		p.cs_xram = ctl[3];
		p.phi     = ctl[4];
		p.reset   = ctl[5];
		return p;
	endfunction

	// no read is running, so data_dir stays zero.
	function automatic bus_snapshot_t make_snapshot(input cart_pins_t p);
		bus_snapshot_t s;
		s         = '0;
		s.reset   = p.reset;
		s.phi     = p.phi;
		s.wr      = p.wr;
		s.rd      = p.rd;
		s.cs_xram = p.cs_xram;
		s.data    = p.data;
		s.cs_rom  = p.cs_rom;
		s.adr     = p.adr;
		return s;
	endfunction

	// ************************************************************************
	// bus tasks
	// ************************************************************************

	task automatic host_write(input logic [15:0] addr, input logic [7:0] value);
		@(posedge cpuclk);
		host <= '{adr: addr, wdata: value, wr: 1'b1, rd: 1'b0};
		@(posedge cpuclk);
		host.wr <= 1'b0;
	endtask

	task automatic host_read(input logic [15:0] addr, output logic [7:0] value);
		@(posedge cpuclk);
		host <= '{adr: addr, wdata: 8'h00, wr: 1'b0, rd: 1'b1};
		@(posedge cpuclk);
		host.rd <= 1'b0;
		@(negedge cpuclk);   // rdata lands one cycle after rd.
		value = rdata;
	endtask

	task automatic atom_load(input logic [31:0] word);
		for (int i = 0; i < 4; i++)
			host_write(ATOM_BASE + 16'(i), word[i*8 +: 8]);
	endtask

	task automatic wait_bus_idle();
		int n;
		n = 0;
		do begin
			@(negedge cpuclk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run($sformatf("%s: timed out waiting for the data bus to turn around",
					test_name));
		end while (cart_data_oe || shifter_dir);
	endtask

	task automatic cart_read(input logic [15:0] addr, input logic [7:0] exp);
		int n;
		n = 0;
		@(posedge cpuclk);
		cart <= make_pins(addr, 8'h00, CTL_READ);
		do begin
			@(negedge cpuclk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run($sformatf("%s: timed out waiting for cart_data_oe", test_name));
		end while (!cart_data_oe);
		check_bit("shifter_dir", 1'b1, shifter_dir);
		check_bit("shifter_en", 1'b1, shifter_en);
		check_byte("cart_data_out", exp, cart_data_out);
		@(posedge cpuclk);
		cart <= '0;
		wait_bus_idle();
	endtask

	task automatic cart_write(input logic [15:0] addr, input logic [7:0] value);
		@(posedge cpuclk);
		cart <= make_pins(addr, value, CTL_XWRITE);
		@(posedge cpuclk);
		cart <= '0;
	endtask

	task automatic route_probe(input logic [15:0] addr, input logic [7:0] ctl,
			input logic [NUM_ROUTES-1:0] exp);
		@(posedge cpuclk);
		cart <= make_pins(addr, 8'h00, ctl);
		repeat (2) @(posedge cpuclk);   // input register, then the registered match
		@(negedge cpuclk);
		check_routes(exp, routes);
		@(posedge cpuclk);
		cart <= '0;
		repeat (2) @(posedge cpuclk);
		wait_bus_idle();
	endtask

	task automatic snapshot_readback(input logic [15:0] addr, input logic [7:0] data,
			input logic [7:0] ctl);
		cart_pins_t    p;
		bus_snapshot_t s;
		logic [7:0]    value;
		p = make_pins(addr, data, ctl);
		s = make_snapshot(p);
		@(posedge cpuclk);
		cart <= p;
		for (int i = 0; i < 4; i++) begin
			host_read(DUT_BASE + 16'(i), value);
			check_byte($sformatf("snapshot byte %0d", i), s[i*8 +: 8], value);
		end
		@(posedge cpuclk);
		cart <= '0;
	endtask

	// ************************************************************************
	// trace player
	// ************************************************************************

	initial begin
		int          fd;
		int          line_no;
		int          n;
		string       line;
		string       op;
		logic [31:0] adr, data, ctl, exp, rnd;
		logic [7:0]  value;

		cpuclk    = 1'b0;
		f_reset   = 1'b1;
		host      = '0;
		cart      = '0;
		test_name = "reset";
		void'($urandom(32'hb49753bb));
		fd = $fopen(TRACE, "r");
		if (fd == 0)
			abort_run("could not open the trace file dv/cart_monitor_trace.txt");
		repeat (3) @(posedge cpuclk);
		f_reset <= 1'b0;

		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h", op, adr, data, ctl, exp, rnd);
			if (n != 6)
				abort_run($sformatf("trace line %0d could not be parsed", line_no));
			test_name = $sformatf("line %0d %s", line_no, op);
			case (op)
				"hw": begin
					value = rnd[0] ? 8'($urandom) : data[7:0];
					if (adr[15:RAM_AW] == CART_RAM_BASE[15:RAM_AW])
						rom_model[adr[RAM_AW-1:0]] = value;   // window writes the rom image.
					host_write(adr[15:0], value);
				end
				"hr": begin
					host_read(adr[15:0], value);
					check_byte("rdata", rnd[0] ? xram_model[adr[RAM_AW-1:0]] : exp[7:0], value);
				end
				"cr": cart_read(adr[15:0], rnd[0] ? rom_model[adr[RAM_AW-1:0]] : exp[7:0]);
				"cw": begin
					value = rnd[0] ? 8'($urandom) : data[7:0];
					if (adr[13])
						xram_model[adr[RAM_AW-1:0]] = value;  // only bit 13 writes land.
					cart_write(adr[15:0], value);
				end
				"at": atom_load(data);
				"rt": route_probe(adr[15:0], ctl[7:0], exp[NUM_ROUTES-1:0]);
				"pa": begin
					@(posedge cpuclk);
					@(negedge cpuclk);
					check_pa(exp[7:0], pa_out);
				end
				"rs": begin
					@(negedge cpuclk);
					check_bit("cart_reset_drive", exp[0], cart_reset_drive);
				end
				"sn": snapshot_readback(adr[15:0], data[7:0], ctl[7:0]);
				default: abort_run($sformatf("trace line %0d has an unknown operation %s",
					line_no, op));
			endcase
		end
		$fclose(fd);

		$display("Test OK");
		$finish;
	end

endmodule

// File: dv/cart_monitor_trace.txt
# op adr data ctl exp rnd, all hex; rnd 1 draws data (hw, cw) or takes exp from the model (hr, cr)
# hw hr host write and read, cr cw cart read and write, at atom word, rt routes, pa port A
# rs reset drive, sn snapshot read-back; ctl bits from bit 0: rd wr cs_rom cs_xram phi reset
hw 1456 00 00 00 1
hw 1457 00 00 00 1
cr 0456 00 00 00 1
cr 0457 00 00 00 1
cw 2123 00 00 00 1
cw 0123 00 00 00 1
hr 1123 00 00 00 1
cw 2200 00 00 00 1
hr 1200 00 00 00 1
hw ff52 5a 00 00 0
hw ff50 03 00 00 0
cr 0456 00 00 5a 0
rs 0000 00 00 01 0
hw ff50 0c 00 00 0
cr 0456 00 00 00 1
rs 0000 00 00 00 0
at 0000 04008456 00 00 0
hw ff53 01 00 00 0
at 0000 0400ffff 00 00 0
hw ff53 02 00 00 0
at 0000 00000008 00 00 0
hw ff14 00 00 00 0
at 0000 00000005 00 00 0
hw ff51 01 00 00 0
rt 0457 00 05 08 0
rt 0456 00 05 0d 0
hw ff40 3c 00 00 0
pa 0000 00 00 3c 0
hw ff41 24 00 00 0
pa 0000 00 00 18 0
at 0000 00000001 00 00 0
hw ff42 01 00 00 0
pa 0000 00 00 18 0
rt 0456 00 05 0d 0
pa 0000 00 00 19 0
sn 4321 a7 39 00 0
hr ff30 00 00 ff 0

// File: hw/cart_monitor_top.sv
`timescale 1ns/1ps

module cart_monitor_top import cart_pkg::*; #(
	parameter int RAM_AW     = 12,
	parameter int NUM_ROUTES = 4
) (
	input  logic                  cpuclk,
	input  logic                  f_reset,
	input  host_req_t             host,
	output logic [HOST_DW-1:0]    rdata,
	input  cart_pins_t            cart,
	output logic [7:0]            cart_data_out,
	output logic                  cart_data_oe,
	output logic                  shifter_dir,
	output logic                  shifter_en,
	output logic                  cart_reset_drive,
	output logic [NUM_ROUTES-1:0] routes,
	output logic [7:0]            pa_out
);

	cart_ctl_t         ctl;
	trig_cfg_t         cfg;
	bus_snapshot_t     snapshot;
	logic              host_ram_wr;
	logic [RAM_AW-1:0] host_ram_adr;
	logic [7:0]        host_ram_wdata;
	logic [7:0]        host_ram_rdata;
	logic [RAM_AW-1:0] cart_ram_adr;
	logic              cart_ram_wr;
	logic [7:0]        cart_ram_wdata;
	logic [7:0]        rom_data;

	host_regs #(.RAM_AW(RAM_AW)) u_host_regs (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.host      (host),
		.rdata     (rdata),
		.snapshot  (snapshot),
		.ram_rdata (host_ram_rdata),
		.ram_wr    (host_ram_wr),
		.ram_adr   (host_ram_adr),
		.ram_wdata (host_ram_wdata),
		.ctl       (ctl),
		.cfg       (cfg)
	);

	cart_bus_port #(.RAM_AW(RAM_AW)) u_cart_bus_port (
		.cpuclk           (cpuclk),
		.f_reset          (f_reset),
		.cart             (cart),
		.ctl              (ctl),
		.rom_data         (rom_data),
		.ram_adr          (cart_ram_adr),
		.cart_wr          (cart_ram_wr),
		.wdata            (cart_ram_wdata),
		.cart_data_out    (cart_data_out),
		.cart_data_oe     (cart_data_oe),
		.shifter_dir      (shifter_dir),
		.shifter_en       (shifter_en),
		.cart_reset_drive (cart_reset_drive),
		.snapshot         (snapshot)
	);

	cart_ram #(.RAM_AW(RAM_AW)) u_cart_ram (
		.cpuclk     (cpuclk),
		.host_wr    (host_ram_wr),
		.host_adr   (host_ram_adr),
		.host_wdata (host_ram_wdata),
		.host_rdata (host_ram_rdata),
		.cart_adr   (cart_ram_adr),
		.cart_wr    (cart_ram_wr),
		.cart_wdata (cart_ram_wdata),
		.rom_data   (rom_data)
	);

	trigger_router #(.NUM_ROUTES(NUM_ROUTES)) u_trigger_router (
		.cpuclk   (cpuclk),
		.f_reset  (f_reset),
		.snapshot (snapshot),
		.cfg      (cfg),
		.routes   (routes),
		.pa_out   (pa_out)
	);

endmodule

// File: hw/host_regs.sv
`timescale 1ns/1ps

module host_regs import cart_pkg::*; #(
	parameter int RAM_AW = 12
) (
	input  logic               cpuclk,
	input  logic               f_reset,
	input  host_req_t          host,
	output logic [HOST_DW-1:0] rdata,
	input  bus_snapshot_t      snapshot,
	input  logic [7:0]         ram_rdata,
	output logic               ram_wr,
	output logic [RAM_AW-1:0]  ram_adr,
	output logic [7:0]         ram_wdata,
	output cart_ctl_t          ctl,
	output trig_cfg_t          cfg
);

	logic               sel_ram, sel_atom, sel_ones, sel_pa, sel_dut;
	logic               wr_q;
	logic [15:0]        adr_q;
	logic               wr_edge;
	logic               dut_wr, pa_wr;
	logic [4:0]         byte_sel;
	atom_u              atom;
	logic [7:0]         ovr_data;
	logic [HOST_DW-1:0] rdata_q;
	logic               rd_ram_q;

	// ************************************************************************
	// address decode
	// ************************************************************************

	assign sel_ram  = host.adr[15:RAM_AW] == CART_RAM_BASE[15:RAM_AW];
	assign sel_atom = host.adr[15:2] == ATOM_BASE[15:2];
	assign sel_ones = host.adr == ONES_ADR;
	assign sel_pa   = host.adr[15:2] == PA_BASE[15:2];
	assign sel_dut  = host.adr[15:2] == DUT_BASE[15:2];

	assign byte_sel = {host.adr[1:0], 3'b000};

	// an action fires only on the first cycle of a write to a register.
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			wr_q <= 1'b0;
		else
			wr_q <= host.wr;
		adr_q <= host.adr;
	end

	assign wr_edge = host.wr && !(wr_q && adr_q == host.adr);
	assign dut_wr  = wr_edge && sel_dut;
	assign pa_wr   = wr_edge && sel_pa;

	assign ram_wr    = wr_edge && sel_ram;
	assign ram_adr   = host.adr[RAM_AW-1:0];
	assign ram_wdata = host.wdata;

	// ************************************************************************
	// registers
	// ************************************************************************

	always_ff @(posedge cpuclk) begin
		if (wr_edge && sel_atom)
			atom[byte_sel +: 8] <= host.wdata;
		if (dut_wr && host.adr[1:0] == 2'd2)
			ovr_data <= host.wdata;              // override byte.
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			cfg <= '0;
		end else begin
			cfg.pa_strobe <= pa_wr && !host.adr[1];  // masks and strobe land together.
			if (wr_edge && sel_ones)
				cfg.ones_routes <= atom.routes.route;
			if (dut_wr && host.adr[1:0] == 2'd1 && host.wdata == 8'd1)
				cfg.cmp_routes <= atom.routes.route;
			if (dut_wr && host.adr[1:0] == 2'd3 && host.wdata[0])
				cfg.cmp_value <= atom.compare;
			if (dut_wr && host.adr[1:0] == 2'd3 && host.wdata[1])
				cfg.cmp_mask <= atom.compare;
			if (pa_wr && host.adr[1:0] == 2'd0)
				cfg.pa_set <= host.wdata;
			if (pa_wr && host.adr[1:0] == 2'd1)
				cfg.pa_clr <= host.wdata;
			if (pa_wr && host.adr[1:0] == 2'd2 && host.wdata == 8'd1)
				cfg.pa_trig_set <= atom.routes.route;
			if (pa_wr && host.adr[1:0] == 2'd3 && host.wdata == 8'd1)
				cfg.pa_trig_clr <= atom.routes.route;
		end
	end

	// control byte pulses, the bus port holds the flags.
	always_comb begin
		ctl.reset_set = dut_wr && host.adr[1:0] == 2'd0 && host.wdata[0];
		ctl.ovr_set   = dut_wr && host.adr[1:0] == 2'd0 && host.wdata[1];
		ctl.reset_clr = dut_wr && host.adr[1:0] == 2'd0 && host.wdata[2];
		ctl.ovr_clr   = dut_wr && host.adr[1:0] == 2'd0 && host.wdata[3];
		ctl.ovr_data  = ovr_data;
	end

	// ************************************************************************
	// read back
	// ************************************************************************

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			rd_ram_q <= 1'b0;
		else
			rd_ram_q <= host.rd && sel_ram;  // ram output is already one cycle late.
		if (host.rd) begin
			if (sel_atom)
				rdata_q <= atom[byte_sel +: 8];
			else if (sel_dut)
				rdata_q <= snapshot[byte_sel +: 8];
			else
				rdata_q <= UNMAPPED_READ;
		end
	end

	assign rdata = rd_ram_q ? ram_rdata : rdata_q;

	a_one_select: assert property (@(posedge cpuclk) disable iff (f_reset)
		$onehot0({sel_ram, sel_atom, sel_ones, sel_pa, sel_dut}));

endmodule

// File: hw/trigger_router.sv
`timescale 1ns/1ps

module trigger_router import cart_pkg::*; #(
	parameter int NUM_ROUTES = 4
) (
	input  logic                  cpuclk,
	input  logic                  f_reset,
	input  bus_snapshot_t         snapshot,
	input  trig_cfg_t             cfg,
	output logic [NUM_ROUTES-1:0] routes,
	output logic [7:0]            pa_out
);

	logic                  match;
	logic                  match_q;
	logic [NUM_ROUTES-1:0] cmp_sel;
	logic [NUM_ROUTES-1:0] ones_sel;
	logic [NUM_ROUTES-1:0] pa_set_sel;
	logic [NUM_ROUTES-1:0] pa_clr_sel;
	logic [7:0]            set_mask;
	logic [7:0]            clr_mask;

	assign cmp_sel    = cfg.cmp_routes[NUM_ROUTES-1:0];
	assign ones_sel   = cfg.ones_routes[NUM_ROUTES-1:0];
	assign pa_set_sel = cfg.pa_trig_set[NUM_ROUTES-1:0];
	assign pa_clr_sel = cfg.pa_trig_clr[NUM_ROUTES-1:0];

	// ************************************************************************
	// masked compare and route combine
	// ************************************************************************

	assign match = ((snapshot ^ cfg.cmp_value) & cfg.cmp_mask) == '0;

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			match_q <= 1'b0;
		else
			match_q <= match;
	end

	assign routes = ones_sel | ({NUM_ROUTES{match_q}} & cmp_sel);

	// ************************************************************************
	// port A
	// ************************************************************************

	// host masks apply on the strobe and routes drive bit 0 on every cycle.
	always_comb begin
		set_mask    = cfg.pa_strobe ? cfg.pa_set : 8'h00;
		clr_mask    = cfg.pa_strobe ? cfg.pa_clr : 8'h00;
		set_mask[0] = set_mask[0] || |(pa_set_sel & routes);
		clr_mask[0] = clr_mask[0] || |(pa_clr_sel & routes);
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			pa_out <= 8'h00;
		else
			pa_out <= (pa_out | set_mask) & ~clr_mask;  // clear wins.
	end

	a_pa_hold: assert property (@(posedge cpuclk) disable iff (f_reset)
		!cfg.pa_strobe && !(|((pa_set_sel | pa_clr_sel) & routes)) |=> $stable(pa_out));

endmodule

// File: vlog.f
common/cart_pkg.sv
cart_bus/cart_ram.sv
cart_bus/cart_bus_port.sv
hw/host_regs.sv
hw/trigger_router.sv
hw/cart_monitor_top.sv
dv/cart_monitor_tb.sv
